// File: src/soc_pkg.sv
package soc_pkg;

	// ========================================================
	// Bus widths and memory map
	// ========================================================

	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;

	// Word RAM, byte addresses 0x10000000 to 0x100003FC
	localparam int RAM_WORDS = 256;
	localparam int RAM_IDX_W = $clog2(RAM_WORDS);

	// Block RAM lives at 0x1xxxxxxx
	localparam logic [3:0] SEL_RAM = 4'h1;
	// DMA register block at 0x9xxxxxxx
	localparam logic [3:0] SEL_DMA = 4'h9;
	// Timer at 0xAxxxxxxx
	localparam logic [3:0] SEL_TIMER = 4'hA;

	// ========================================================
	// Register offsets, taken from address bits 3:2
	// ========================================================

	localparam logic [1:0] DMA_REG_SRC    = 2'd0;
	localparam logic [1:0] DMA_REG_DST    = 2'd1;
	localparam logic [1:0] DMA_REG_COUNT  = 2'd2;
	localparam logic [1:0] DMA_REG_STATUS = 2'd3;

	localparam logic [1:0] TMR_REG_COUNT   = 2'd0;
	localparam logic [1:0] TMR_REG_COMPARE = 2'd1;
	localparam logic [1:0] TMR_REG_CTRL    = 2'd2;

	// ========================================================
	// State encodings
	// ========================================================

	// Bus owner
	typedef enum logic [1:0] {
		GRANT_NONE,
		GRANT_HOST,
		GRANT_DMA
	} grant_t;

	// Copy engine
	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_READ,
		DMA_WRITE
	} dma_state_t;

endpackage

// File: src/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
	input  logic                        clock,
	input  logic                        i_rst_n,

	// Port A from the host
	input  logic                        i_a_request,
	input  logic                        i_a_rw,
	input  logic [soc_pkg::ADDR_W-1:0]  i_a_address,
	input  logic [soc_pkg::DATA_W-1:0]  i_a_wdata,
	output logic [soc_pkg::DATA_W-1:0]  o_a_rdata,
	output logic                        o_a_ready,

	// Port B from the DMA master
	input  logic                        i_b_request,
	input  logic                        i_b_rw,
	input  logic [soc_pkg::ADDR_W-1:0]  i_b_address,
	input  logic [soc_pkg::DATA_W-1:0]  i_b_wdata,
	output logic [soc_pkg::DATA_W-1:0]  o_b_rdata,
	output logic                        o_b_ready,

	// Shared bus
	output logic                        o_bus_request,
	output logic                        o_bus_rw,
	output logic [soc_pkg::ADDR_W-1:0]  o_bus_address,
	output logic [soc_pkg::DATA_W-1:0]  o_bus_wdata,
	input  logic [soc_pkg::DATA_W-1:0]  i_bus_rdata,
	input  logic                        i_bus_ready
);

	soc_pkg::grant_t grant;

	// Grant is taken only from idle and held until the slave answers
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			grant <= soc_pkg::GRANT_NONE;
		end else begin
			case (grant)
				soc_pkg::GRANT_NONE: begin
					if (i_a_request)
						grant <= soc_pkg::GRANT_HOST;
					else if (i_b_request)
						grant <= soc_pkg::GRANT_DMA;
				end
				default: begin
					if (i_bus_ready)
						grant <= soc_pkg::GRANT_NONE;
				end
			endcase
		end
	end

	// Route the owner onto the bus
	always_comb begin
		o_bus_request = 1'b0;
		o_bus_rw      = 1'b0;
		o_bus_address = '0;
		o_bus_wdata   = '0;
		case (grant)
			soc_pkg::GRANT_HOST: begin
				o_bus_request = i_a_request;
				o_bus_rw      = i_a_rw;
				o_bus_address = i_a_address;
				o_bus_wdata   = i_a_wdata;
			end
			soc_pkg::GRANT_DMA: begin
				o_bus_request = i_b_request;
				o_bus_rw      = i_b_rw;
				o_bus_address = i_b_address;
				o_bus_wdata   = i_b_wdata;
			end
			default: ;
		endcase
	end

	assign o_a_ready = (grant == soc_pkg::GRANT_HOST) && i_bus_ready;
	assign o_b_ready = (grant == soc_pkg::GRANT_DMA) && i_bus_ready;
	assign o_a_rdata = (grant == soc_pkg::GRANT_HOST) ? i_bus_rdata : '0;
	assign o_b_rdata = (grant == soc_pkg::GRANT_DMA) ? i_bus_rdata : '0;

	// A slave answers only a transfer that is still on the bus
	a_ready_in_transfer: assert property (@(posedge clock) disable iff (!i_rst_n)
		i_bus_ready |-> o_bus_request);

endmodule

// File: src/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder (
	input  logic                           clock,
	input  logic                           i_rst_n,
	input  logic                           i_request,
	input  logic [soc_pkg::ADDR_W-1:0]     i_address,
	output logic                           o_ready,
	output logic [soc_pkg::DATA_W-1:0]     o_rdata,
	output logic                           o_fault,

	output logic                           o_ram_request,
	output logic [soc_pkg::RAM_IDX_W-1:0]  o_ram_index,
	input  logic [soc_pkg::DATA_W-1:0]     i_ram_rdata,
	input  logic                           i_ram_ready,

	output logic                           o_dma_request,
	input  logic [soc_pkg::DATA_W-1:0]     i_dma_rdata,
	input  logic                           i_dma_ready,

	output logic                           o_tmr_request,
	input  logic [soc_pkg::DATA_W-1:0]     i_tmr_rdata,
	input  logic                           i_tmr_ready,

	output logic [1:0]                     o_reg_offset
);

	logic [3:0] sel;
	logic       hit_ram;
	logic       hit_dma;
	logic       hit_tmr;
	logic       miss_ready;

	assign sel     = i_address[soc_pkg::ADDR_W-1 -: 4];
	assign hit_ram = sel == soc_pkg::SEL_RAM;
	assign hit_dma = sel == soc_pkg::SEL_DMA;
	assign hit_tmr = sel == soc_pkg::SEL_TIMER;

	assign o_ram_request = i_request && hit_ram;
	assign o_dma_request = i_request && hit_dma;
	assign o_tmr_request = i_request && hit_tmr;
	assign o_ram_index   = i_address[2 +: soc_pkg::RAM_IDX_W];
	assign o_reg_offset  = i_address[3:2];

	// Unmapped address, answer here so the master is not left hanging
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n)
			miss_ready <= 1'b0;
		else
			miss_ready <= i_request && !(hit_ram || hit_dma || hit_tmr) && !miss_ready;
	end

	assign o_fault = miss_ready;

	assign o_ready = hit_ram ? i_ram_ready :
	                 hit_dma ? i_dma_ready :
	                 hit_tmr ? i_tmr_ready :
	                 miss_ready;

	assign o_rdata = hit_ram ? i_ram_rdata :
	                 hit_dma ? i_dma_rdata :
	                 hit_tmr ? i_tmr_rdata :
	                 '0;

	a_single_ready: assert property (@(posedge clock) disable iff (!i_rst_n)
		$onehot0({i_ram_ready, i_dma_ready, i_tmr_ready, miss_ready}));

endmodule

// File: src/bram.sv
`timescale 1ns/1ps

module bram (
	input  logic                           clock,
	input  logic                           i_rst_n,
	input  logic                           i_request,
	input  logic                           i_rw,
	input  logic [soc_pkg::RAM_IDX_W-1:0]  i_index,
	input  logic [soc_pkg::DATA_W-1:0]     i_wdata,
	output logic [soc_pkg::DATA_W-1:0]     o_rdata,
	output logic                           o_ready
);

	logic [soc_pkg::DATA_W-1:0] mem [soc_pkg::RAM_WORDS];
	logic                       accept;

	// Request seen in the ready cycle belongs to the finished transfer
	assign accept = i_request && !o_ready;

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n)
			o_ready <= 1'b0;
		else
			o_ready <= accept;
	end

	// Storage and read port
	always_ff @(posedge clock) begin
		if (accept) begin
			if (i_rw)
				mem[i_index] <= i_wdata;
			else
				o_rdata <= mem[i_index];
		end
	end

endmodule

// File: src/dma_engine.sv
`timescale 1ns/1ps

module dma_engine (
	input  logic                        clock,
	input  logic                        i_rst_n,

	// Register port
	input  logic                        i_request,
	input  logic                        i_rw,
	input  logic [1:0]                  i_offset,
	input  logic [soc_pkg::DATA_W-1:0]  i_wdata,
	output logic [soc_pkg::DATA_W-1:0]  o_rdata,
	output logic                        o_ready,

	// Master port
	output logic                        o_mreq,
	output logic                        o_mrw,
	output logic [soc_pkg::ADDR_W-1:0]  o_maddr,
	output logic [soc_pkg::DATA_W-1:0]  o_mwdata,
	input  logic [soc_pkg::DATA_W-1:0]  i_mrdata,
	input  logic                        i_mready
);

	soc_pkg::dma_state_t state;

	logic [soc_pkg::ADDR_W-1:0] src_addr;
	logic [soc_pkg::ADDR_W-1:0] dst_addr;
	logic [soc_pkg::DATA_W-1:0] count;
	logic [soc_pkg::DATA_W-1:0] data;
	logic                       busy;
	logic                       accept;

	assign busy   = state != soc_pkg::DMA_IDLE;
	assign accept = i_request && !o_ready;

	// ========================================================
	// Register port
	// ========================================================

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n)
			o_ready <= 1'b0;
		else
			o_ready <= accept;
	end

	always_ff @(posedge clock) begin
		if (accept && !i_rw) begin
			case (i_offset)
				soc_pkg::DMA_REG_SRC:   o_rdata <= src_addr;
				soc_pkg::DMA_REG_DST:   o_rdata <= dst_addr;
				soc_pkg::DMA_REG_COUNT: o_rdata <= count;
				default:                o_rdata <= {{(soc_pkg::DATA_W-1){1'b0}}, busy};
			endcase
		end
	end

	// ========================================================
	// Copy FSM
	// ========================================================

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= soc_pkg::DMA_IDLE;
			src_addr <= '0;
			dst_addr <= '0;
			count    <= '0;
		end else begin
			case (state)
				soc_pkg::DMA_IDLE: begin
					// Programming only while idle
					if (accept && i_rw) begin
						case (i_offset)
							soc_pkg::DMA_REG_SRC: src_addr <= i_wdata;
							soc_pkg::DMA_REG_DST: dst_addr <= i_wdata;
							soc_pkg::DMA_REG_COUNT: begin
								count <= i_wdata;
								if (i_wdata != '0)
									state <= soc_pkg::DMA_READ;
							end
							default: ;
						endcase
					end
				end
				soc_pkg::DMA_READ: begin
					if (i_mready)
						state <= soc_pkg::DMA_WRITE;
				end
				soc_pkg::DMA_WRITE: begin
					if (i_mready) begin
						src_addr <= src_addr + 4;
						dst_addr <= dst_addr + 4;
						count    <= count - 1;
						// Last word written
						state    <= (count == 1) ? soc_pkg::DMA_IDLE : soc_pkg::DMA_READ;
					end
				end
				default: state <= soc_pkg::DMA_IDLE;
			endcase
		end
	end

	// Word in flight between read and write
	always_ff @(posedge clock) begin
		if (state == soc_pkg::DMA_READ && i_mready)
			data <= i_mrdata;
	end

	assign o_mreq   = busy;
	assign o_mrw    = state == soc_pkg::DMA_WRITE;
	assign o_maddr  = (state == soc_pkg::DMA_WRITE) ? dst_addr : src_addr;
	assign o_mwdata = data;

	a_count_live: assert property (@(posedge clock) disable iff (!i_rst_n)
		busy |-> count != '0);

	// Master holds its transfer until the arbiter returns ready
	a_master_hold: assert property (@(posedge clock) disable iff (!i_rst_n)
		(o_mreq && !i_mready) |=> (o_mreq && $stable(o_maddr) && $stable(o_mrw)));

endmodule

// File: src/timer.sv
`timescale 1ns/1ps

module timer (
	input  logic                        clock,
	input  logic                        i_rst_n,
	input  logic                        i_request,
	input  logic                        i_rw,
	input  logic [1:0]                  i_offset,
	input  logic [soc_pkg::DATA_W-1:0]  i_wdata,
	output logic [soc_pkg::DATA_W-1:0]  o_rdata,
	output logic                        o_ready,
	output logic                        o_irq
);

	logic [soc_pkg::DATA_W-1:0] count;
	logic [soc_pkg::DATA_W-1:0] compare;
	logic                       enable;
	logic                       accept;
	logic                       wr_ctrl;

	assign accept  = i_request && !o_ready;
	assign wr_ctrl = accept && i_rw && (i_offset == soc_pkg::TMR_REG_CTRL);

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ready <= 1'b0;
			count   <= '0;
			compare <= '0;
			enable  <= 1'b0;
			o_irq   <= 1'b0;
		end else begin
			o_ready <= accept;

			// Count register, writes take priority over the increment
			if (accept && i_rw && i_offset == soc_pkg::TMR_REG_COUNT)
				count <= i_wdata;
			else if (enable)
				count <= count + 1;

			if (accept && i_rw && i_offset == soc_pkg::TMR_REG_COMPARE)
				compare <= i_wdata;

			if (wr_ctrl)
				enable <= i_wdata[0];

			// Sticky until software touches ctrl
			if (wr_ctrl)
				o_irq <= 1'b0;
			else if (enable && count == compare)
				o_irq <= 1'b1;
		end
	end

	// Read mux, ctrl shows irq in bit 1
	always_ff @(posedge clock) begin
		if (accept && !i_rw) begin
			case (i_offset)
				soc_pkg::TMR_REG_COUNT:   o_rdata <= count;
				soc_pkg::TMR_REG_COMPARE: o_rdata <= compare;
				soc_pkg::TMR_REG_CTRL:    o_rdata <= {{(soc_pkg::DATA_W-2){1'b0}}, o_irq, enable};
				default:                  o_rdata <= '0;
			endcase
		end
	end

endmodule

// File: src/soc_bus.sv
`timescale 1ns/1ps

module soc_bus (
	input  logic                        clock,
	input  logic                        i_rst_n,
	input  logic                        i_host_request,
	input  logic                        i_host_rw,
	input  logic [soc_pkg::ADDR_W-1:0]  i_host_address,
	input  logic [soc_pkg::DATA_W-1:0]  i_host_wdata,
	output logic [soc_pkg::DATA_W-1:0]  o_host_rdata,
	output logic                        o_host_ready,
	output logic                        o_timer_irq,
	output logic                        o_bus_fault
);

	// DMA master side
	logic                          dma_mreq;
	logic                          dma_mrw;
	logic [soc_pkg::ADDR_W-1:0]    dma_maddr;
	logic [soc_pkg::DATA_W-1:0]    dma_mwdata;
	logic [soc_pkg::DATA_W-1:0]    dma_mrdata;
	logic                          dma_mready;

	// Shared bus
	logic                          bus_request;
	logic                          bus_rw;
	logic [soc_pkg::ADDR_W-1:0]    bus_address;
	logic [soc_pkg::DATA_W-1:0]    bus_wdata;
	logic [soc_pkg::DATA_W-1:0]    bus_rdata;
	logic                          bus_ready;

	// Slave side
	logic                          ram_request;
	logic [soc_pkg::RAM_IDX_W-1:0] ram_index;
	logic [soc_pkg::DATA_W-1:0]    ram_rdata;
	logic                          ram_ready;
	logic                          dma_request;
	logic [soc_pkg::DATA_W-1:0]    dma_rdata;
	logic                          dma_ready;
	logic                          tmr_request;
	logic [soc_pkg::DATA_W-1:0]    tmr_rdata;
	logic                          tmr_ready;
	logic [1:0]                    reg_offset;

	// ========================================================
	// Masters and arbitration
	// ========================================================

	bus_arbiter u_arbiter (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_a_request(i_host_request), .i_a_rw(i_host_rw),
		.i_a_address(i_host_address), .i_a_wdata(i_host_wdata),
		.o_a_rdata(o_host_rdata), .o_a_ready(o_host_ready),
		.i_b_request(dma_mreq), .i_b_rw(dma_mrw),
		.i_b_address(dma_maddr), .i_b_wdata(dma_mwdata),
		.o_b_rdata(dma_mrdata), .o_b_ready(dma_mready),
		.o_bus_request(bus_request), .o_bus_rw(bus_rw),
		.o_bus_address(bus_address), .o_bus_wdata(bus_wdata),
		.i_bus_rdata(bus_rdata), .i_bus_ready(bus_ready)
	);

	addr_decoder u_decoder (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_request(bus_request), .i_address(bus_address),
		.o_ready(bus_ready), .o_rdata(bus_rdata), .o_fault(o_bus_fault),
		.o_ram_request(ram_request), .o_ram_index(ram_index),
		.i_ram_rdata(ram_rdata), .i_ram_ready(ram_ready),
		.o_dma_request(dma_request), .i_dma_rdata(dma_rdata), .i_dma_ready(dma_ready),
		.o_tmr_request(tmr_request), .i_tmr_rdata(tmr_rdata), .i_tmr_ready(tmr_ready),
		.o_reg_offset(reg_offset)
	);

	// ========================================================
	// Slaves
	// ========================================================

	bram u_ram (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_request(ram_request), .i_rw(bus_rw), .i_index(ram_index),
		.i_wdata(bus_wdata), .o_rdata(ram_rdata), .o_ready(ram_ready)
	);

	dma_engine u_dma (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_request(dma_request), .i_rw(bus_rw), .i_offset(reg_offset),
		.i_wdata(bus_wdata), .o_rdata(dma_rdata), .o_ready(dma_ready),
		.o_mreq(dma_mreq), .o_mrw(dma_mrw), .o_maddr(dma_maddr),
		.o_mwdata(dma_mwdata), .i_mrdata(dma_mrdata), .i_mready(dma_mready)
	);

	timer u_timer (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_request(tmr_request), .i_rw(bus_rw), .i_offset(reg_offset),
		.i_wdata(bus_wdata), .o_rdata(tmr_rdata), .o_ready(tmr_ready),
		.o_irq(o_timer_irq)
	);

endmodule

// File: bench/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;

	localparam int          TIMEOUT_CYCLES = 2000;
	localparam logic [31:0] SEED           = 32'hc9ce_8884;

	logic                       clock;
	logic                       i_rst_n;
	logic                       i_host_request;
	logic                       i_host_rw;
	logic [soc_pkg::ADDR_W-1:0] i_host_address;
	logic [soc_pkg::DATA_W-1:0] i_host_wdata;
	logic [soc_pkg::DATA_W-1:0] o_host_rdata;
	logic                       o_host_ready;
	logic                       o_timer_irq;
	logic                       o_bus_fault;

	// Expected RAM contents by word index
	logic [31:0] ram_model [int];
	int          written[$];
	int          fault_count = 0;

	soc_bus u_dut (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_host_request(i_host_request), .i_host_rw(i_host_rw),
		.i_host_address(i_host_address), .i_host_wdata(i_host_wdata),
		.o_host_rdata(o_host_rdata), .o_host_ready(o_host_ready),
		.o_timer_irq(o_timer_irq), .o_bus_fault(o_bus_fault)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		if (o_bus_fault)
			fault_count <= fault_count + 1;
	end

	// ==========================================================
	// Helpers
	// ==========================================================

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else
			stop_on_error($sformatf("Mismatch at %0t ns: %s expected 0x%08h, got 0x%08h",
				$time, name, expected, actual));
	endtask

	function automatic logic [31:0] ram_addr(input int idx);
		return {soc_pkg::SEL_RAM, 18'd0, idx[7:0], 2'b00};
	endfunction

	function automatic logic [31:0] reg_addr(input logic [3:0] sel, input logic [1:0] off);
		return {sel, 24'd0, off, 2'b00};
	endfunction

	// Starts 1 ns after an edge and returns 1 ns after the edge that took ready
	task automatic bus_transfer(input logic rw, input logic [31:0] address,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		i_host_request = 1'b1;
		i_host_rw      = rw;
		i_host_address = address;
		i_host_wdata   = wdata;
		@(posedge clock);
		#1;
		while (!o_host_ready) begin
			if (waited == TIMEOUT_CYCLES)
				stop_on_error($sformatf("Host transfer to 0x%08h never got ready", address));
			else begin
				waited++;
				@(posedge clock);
				#1;
			end
		end
		rdata = o_host_rdata;
		@(posedge clock);
		#1;
		i_host_request = 1'b0;
		i_host_rw      = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] address, input logic [31:0] wdata);
		logic [31:0] ignored;
		bus_transfer(1'b1, address, wdata, ignored);
	endtask

	task automatic bus_read(input logic [31:0] address, output logic [31:0] rdata);
		bus_transfer(1'b0, address, 32'd0, rdata);
	endtask

	task automatic ram_write(input int idx, input logic [31:0] wdata);
		bus_write(ram_addr(idx), wdata);
		ram_model[idx] = wdata;
	endtask

	task automatic ram_read_check(input int idx);
		logic [31:0] data;
		bus_read(ram_addr(idx), data);
		check_value($sformatf("o_host_rdata (RAM word %0d)", idx), ram_model[idx], data);
	endtask

	// ==========================================================
	// Protocol checks
	// ==========================================================

	a_reset_quiet: assert property (@(posedge clock)
		!i_rst_n |-> !(o_host_ready || o_timer_irq || o_bus_fault))
		else stop_on_error("An output of the DUT was high while reset was held");

	a_ready_has_request: assert property (@(posedge clock) disable iff (!i_rst_n)
		o_host_ready |-> i_host_request)
		else stop_on_error("o_host_ready rose without a pending host request");

	a_ready_one_cycle: assert property (@(posedge clock) disable iff (!i_rst_n)
		o_host_ready |=> !o_host_ready)
		else stop_on_error("o_host_ready stayed high for more than one cycle");

	// Only host reads go to unmapped space here
	a_fault_answer: assert property (@(posedge clock) disable iff (!i_rst_n)
		o_bus_fault |-> (o_host_ready && o_host_rdata == '0))
		else stop_on_error("o_bus_fault pulsed without a zero ready answer to the host");

	// ==========================================================
	// Stimulus
	// ==========================================================

	initial begin
		int          count;
		int          polls;
		int          waited;
		int          faults_before;
		logic [31:0] data;
		logic [31:0] compare;

		void'($urandom(SEED));
		clock          = 1'b0;
		i_rst_n        = 1'b0;
		i_host_request = 1'b0;
		i_host_rw      = 1'b0;
		i_host_address = '0;
		i_host_wdata   = '0;
		repeat (10) @(posedge clock);
		#1;
		i_rst_n = 1'b1;
		@(posedge clock);
		#1;

		// Random RAM traffic in words 0 to 63
		for (int i = 0; i < 24; i++) begin
			written.push_back(int'($urandom_range(63, 0)));
			ram_write(written[i], $urandom());
		end
		for (int i = 0; i < 24; i++)
			ram_read_check(written[$urandom_range(written.size() - 1, 0)]);

		// DMA copy from word 64 up to word 128 up
		count = int'($urandom_range(16, 1));
		for (int i = 0; i < count; i++)
			ram_write(64 + i, $urandom());
		bus_write(reg_addr(soc_pkg::SEL_DMA, soc_pkg::DMA_REG_SRC), ram_addr(64));
		bus_write(reg_addr(soc_pkg::SEL_DMA, soc_pkg::DMA_REG_DST), ram_addr(128));
		bus_write(reg_addr(soc_pkg::SEL_DMA, soc_pkg::DMA_REG_COUNT), count);

		// Host traffic that competes with the copy
		for (int i = 0; i < 4; i++) begin
			// Idle cycle so the DMA master can win arbitration
			@(posedge clock);
			#1;
			ram_read_check(written[i]);
		end

		polls = 0;
		data  = 32'd1;
		while (data[0]) begin
			if (polls == TIMEOUT_CYCLES)
				stop_on_error("DMA status stayed busy for too long");
			else begin
				polls++;
				@(posedge clock);
				#1;
				bus_read(reg_addr(soc_pkg::SEL_DMA, soc_pkg::DMA_REG_STATUS), data);
			end
		end
		for (int i = 0; i < count; i++) begin
			ram_model[128 + i] = ram_model[64 + i];
			ram_read_check(128 + i);
		end
		bus_read(reg_addr(soc_pkg::SEL_DMA, soc_pkg::DMA_REG_COUNT), data);
		check_value("DMA count register", 32'd0, data);
		bus_read(reg_addr(soc_pkg::SEL_DMA, soc_pkg::DMA_REG_SRC), data);
		check_value("DMA source register", ram_addr(64 + count), data);

		// Unmapped read
		faults_before = fault_count;
		bus_read(32'h7000_0000, data);
		check_value("o_host_rdata (unmapped)", 32'd0, data);
		assert (fault_count == faults_before + 1) else
			stop_on_error("o_bus_fault did not pulse once during the unmapped read");

		// Timer compare interrupt
		compare = $urandom_range(80, 20);
		bus_write(reg_addr(soc_pkg::SEL_TIMER, soc_pkg::TMR_REG_COUNT), 32'd0);
		bus_write(reg_addr(soc_pkg::SEL_TIMER, soc_pkg::TMR_REG_COMPARE), compare);
		bus_write(reg_addr(soc_pkg::SEL_TIMER, soc_pkg::TMR_REG_CTRL), 32'd1);
		waited = 0;
		while (!o_timer_irq) begin
			if (waited == TIMEOUT_CYCLES)
				stop_on_error("o_timer_irq never rose after the timer was enabled");
			else begin
				waited++;
				@(posedge clock);
				#1;
			end
		end
		bus_read(reg_addr(soc_pkg::SEL_TIMER, soc_pkg::TMR_REG_COUNT), data);
		assert (data >= compare) else
			stop_on_error($sformatf("Mismatch at %0t ns: timer count expected >= %0d, got %0d",
				$time, compare, data));
		bus_write(reg_addr(soc_pkg::SEL_TIMER, soc_pkg::TMR_REG_CTRL), 32'd0);
		assert (!o_timer_irq) else
			stop_on_error($sformatf("Mismatch at %0t ns: o_timer_irq expected 0, got %0b",
				$time, o_timer_irq));

		$display("TEST OK");
		$finish;
	end

endmodule

// File: soc_bus.f
src/soc_pkg.sv
src/bus_arbiter.sv
src/addr_decoder.sv
src/bram.sv
src/dma_engine.sv
src/timer.sv
src/soc_bus.sv
bench/tb_soc_bus.sv

// File: run.sh
#!/bin/sh
# Build the soc_bus testbench with Verilator and run it
# The exit status of the simulation is the result of the run
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_soc_bus \
	-Mdir obj_dir -f soc_bus.f &&
./obj_dir/Vtb_soc_bus || { echo "soc_bus simulation did not pass"; exit 1; }
